//--- rtl/axi_sram_pkg.sv
// AXI SRAM shared definitions
package axi_sram_pkg;

    // --------------------------------------------------
    // bus widths
    // --------------------------------------------------
    localparam int ADDR_WIDTH = 16;
    localparam int DATA_WIDTH = 32;
    // one strobe bit per data byte
    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int ID_WIDTH = 4;
    // axi len field, beats minus one
    localparam int LEN_WIDTH = 8;

    // --------------------------------------------------
    // memory geometry
    // --------------------------------------------------
    localparam int MEM_DEPTH = 256;
    localparam int IDX_WIDTH = $clog2(MEM_DEPTH);
    // address bits below word granularity
    localparam int BYTE_OFFSET = $clog2(STRB_WIDTH);

    // response is always okay, no error paths
    localparam logic [1:0] RESP_OKAY = 2'b00;

    // vector types
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [STRB_WIDTH-1:0] strb_t;
    typedef logic [ID_WIDTH-1:0] id_t;
    typedef logic [LEN_WIDTH-1:0] len_t;
    // word index, byte address bits 9:2
    typedef logic [IDX_WIDTH-1:0] word_idx_t;

    // axi burst encoding, 2'b11 is reserved
    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } burst_e;

endpackage

//--- rtl/axi_burst_addr.sv
// AXI burst address generator
`timescale 1ns/1ps

module axi_burst_addr import axi_sram_pkg::*; (
    // address of the beat just handled
    input  addr_t  cur_addr_i,
    // first address of the burst
    input  addr_t  start_addr_i,
    input  len_t   len_i,
    input  burst_e burst_i,
    output addr_t  next_addr_o
);

    // plain increment by one full word
    addr_t incr_addr;
    // total bytes covered by a wrap burst
    addr_t wrap_size;
    // lower edge of the wrap window
    addr_t wrap_lower;
    // wrap only legal for 2, 4, 8 or 16 beats
    logic  wrap_ok;

    always_comb begin
        incr_addr = cur_addr_i + addr_t'(STRB_WIDTH);

        // beats times bytes per beat
        wrap_size = (addr_t'(len_i) + addr_t'(1)) << BYTE_OFFSET;
        // size is a power of two, so mask the start down to it
        wrap_lower = start_addr_i & ~(wrap_size - addr_t'(1));

        wrap_ok = (len_i == len_t'(1)) || (len_i == len_t'(3))
                  || (len_i == len_t'(7)) || (len_i == len_t'(15));

        case (burst_i)
            // every beat hits the start address
            FIXED: next_addr_o = start_addr_i;
            WRAP: begin
                // hitting the upper edge folds back to the lower one
                if (wrap_ok && (incr_addr == wrap_lower + wrap_size)) begin
                    next_addr_o = wrap_lower;
                end else begin
                    // also covers illegal wrap lengths, handled as incr
                    next_addr_o = incr_addr;
                end
            end
            // incr and the reserved encoding
            default: next_addr_o = incr_addr;
        endcase
    end

endmodule

//--- rtl/sram_array.sv
// Single-port SRAM with byte enables
`timescale 1ns/1ps

module sram_array import axi_sram_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    // access strobe, write when we_i is set
    input  logic      req_i,
    input  logic      we_i,
    input  word_idx_t idx_i,
    input  strb_t     be_i,
    input  data_t     wdata_i,
    output data_t     rdata_o
);

    // storage, one entry per word
    data_t mem_q [MEM_DEPTH];
    // registered read port
    data_t rdata_q;

    // --------------------------------------------------
    // write port
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (req_i && we_i) begin
            // only enabled byte lanes are updated
            for (int b = 0; b < STRB_WIDTH; b++) begin
                if (be_i[b]) begin
                    mem_q[idx_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    // --------------------------------------------------
    // read port
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rdata_q <= '0;
        end else if (req_i && !we_i) begin
            // data shows up one cycle after the request
            rdata_q <= mem_q[idx_i];
        end
    end

    assign rdata_o = rdata_q;

endmodule

//--- rtl/axi_mem_if.sv
// AXI to SRAM adapter
`timescale 1ns/1ps

module axi_mem_if import axi_sram_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    // write address channel
    input  logic      aw_valid_i,
    output logic      aw_ready_o,
    input  id_t       aw_id_i,
    input  addr_t     aw_addr_i,
    input  len_t      aw_len_i,
    input  burst_e    aw_burst_i,
    // write data channel
    input  logic      w_valid_i,
    output logic      w_ready_o,
    input  data_t     w_data_i,
    input  strb_t     w_strb_i,
    input  logic      w_last_i,
    // write response channel
    output logic      b_valid_o,
    input  logic      b_ready_i,
    output id_t       b_id_o,
    output logic [1:0] b_resp_o,
    // read address channel
    input  logic      ar_valid_i,
    output logic      ar_ready_o,
    input  id_t       ar_id_i,
    input  addr_t     ar_addr_i,
    input  len_t      ar_len_i,
    input  burst_e    ar_burst_i,
    // read data channel
    output logic      r_valid_o,
    input  logic      r_ready_i,
    output id_t       r_id_o,
    output data_t     r_data_o,
    output logic [1:0] r_resp_o,
    output logic      r_last_o,
    // memory side
    output logic      mem_req_o,
    output logic      mem_we_o,
    output word_idx_t mem_idx_o,
    output strb_t     mem_be_o,
    output data_t     mem_wdata_o,
    input  data_t     mem_rdata_i,
    // burst address generator
    output addr_t     cur_addr_o,
    output addr_t     start_addr_o,
    output len_t      len_o,
    output burst_e    burst_o,
    input  addr_t     next_addr_i
);

    typedef enum logic [2:0] {
        IDLE,
        READ,
        WAIT_WVALID,
        WRITE,
        SEND_B
    } state_e;

    state_e state_d, state_q;
    // attributes of the transaction in progress
    id_t    id_d, id_q;
    addr_t  start_d, start_q;
    len_t   len_d, len_q;
    burst_e burst_d, burst_q;
    // read: beat on the bus; write: last beat written
    addr_t  cur_addr_d, cur_addr_q;
    // read beats already transferred
    len_t   cnt_d, cnt_q;

    // byte address presented to the memory this cycle
    addr_t  mem_addr;
    logic   last_beat;

    // generator always works on the latched burst
    assign cur_addr_o   = cur_addr_q;
    assign start_addr_o = start_q;
    assign len_o        = len_q;
    assign burst_o      = burst_q;

    assign mem_idx_o   = mem_addr[BYTE_OFFSET +: IDX_WIDTH];
    assign mem_be_o    = w_strb_i;
    assign mem_wdata_o = w_data_i;

    // read data comes straight from the memory output register
    assign r_data_o = mem_rdata_i;
    assign r_id_o   = id_q;
    assign r_resp_o = RESP_OKAY;
    assign b_id_o   = id_q;
    assign b_resp_o = RESP_OKAY;

    assign last_beat = (cnt_q == len_q);

    // --------------------------------------------------
    // control FSM
    // --------------------------------------------------
    always_comb begin
        state_d    = state_q;
        id_d       = id_q;
        start_d    = start_q;
        len_d      = len_q;
        burst_d    = burst_q;
        cur_addr_d = cur_addr_q;
        cnt_d      = cnt_q;

        ar_ready_o = 1'b0;
        aw_ready_o = 1'b0;
        w_ready_o  = 1'b0;
        r_valid_o  = 1'b0;
        r_last_o   = 1'b0;
        b_valid_o  = 1'b0;

        mem_req_o = 1'b0;
        mem_we_o  = 1'b0;
        mem_addr  = cur_addr_q;

        case (state_q)
            IDLE: begin
                // reads win when both arrive together
                if (ar_valid_i) begin
                    ar_ready_o = 1'b1;
                    id_d       = ar_id_i;
                    start_d    = ar_addr_i;
                    len_d      = ar_len_i;
                    burst_d    = ar_burst_i;
                    cur_addr_d = ar_addr_i;
                    cnt_d      = '0;
                    // fetch the first word right away
                    mem_req_o  = 1'b1;
                    mem_addr   = ar_addr_i;
                    state_d    = READ;
                end else if (aw_valid_i) begin
                    aw_ready_o = 1'b1;
                    w_ready_o  = 1'b1;
                    id_d       = aw_id_i;
                    start_d    = aw_addr_i;
                    len_d      = aw_len_i;
                    burst_d    = aw_burst_i;
                    cur_addr_d = aw_addr_i;
                    mem_addr   = aw_addr_i;
                    // first beat may already be on the bus
                    if (w_valid_i) begin
                        mem_req_o = 1'b1;
                        mem_we_o  = 1'b1;
                        state_d   = w_last_i ? SEND_B : WRITE;
                    end else begin
                        state_d = WAIT_WVALID;
                    end
                end
            end

            READ: begin
                r_valid_o = 1'b1;
                r_last_o  = last_beat;
                // keep re-reading the same word so r_data holds
                mem_req_o = 1'b1;
                if (r_ready_i) begin
                    if (last_beat) begin
                        mem_req_o = 1'b0;
                        state_d   = IDLE;
                    end else begin
                        // beat consumed, fetch the next one
                        mem_addr   = next_addr_i;
                        cur_addr_d = next_addr_i;
                        cnt_d      = cnt_q + len_t'(1);
                    end
                end
            end

            WAIT_WVALID: begin
                // no beat written yet, target is the start address
                w_ready_o = 1'b1;
                if (w_valid_i) begin
                    mem_req_o = 1'b1;
                    mem_we_o  = 1'b1;
                    state_d   = w_last_i ? SEND_B : WRITE;
                end
            end

            WRITE: begin
                w_ready_o = 1'b1;
                // gaps in w_valid just hold here
                if (w_valid_i) begin
                    mem_req_o  = 1'b1;
                    mem_we_o   = 1'b1;
                    mem_addr   = next_addr_i;
                    cur_addr_d = next_addr_i;
                    if (w_last_i) begin
                        state_d = SEND_B;
                    end
                end
            end

            SEND_B: begin
                b_valid_o = 1'b1;
                if (b_ready_i) begin
                    state_d = IDLE;
                end
            end

            default: state_d = IDLE;
        endcase
    end

    // --------------------------------------------------
    // state registers
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= IDLE;
            id_q       <= '0;
            start_q    <= '0;
            len_q      <= '0;
            burst_q    <= FIXED;
            cur_addr_q <= '0;
            cnt_q      <= '0;
        end else begin
            state_q    <= state_d;
            id_q       <= id_d;
            start_q    <= start_d;
            len_q      <= len_d;
            burst_q    <= burst_d;
            cur_addr_q <= cur_addr_d;
            cnt_q      <= cnt_d;
        end
    end

endmodule

//--- rtl/axi_sram_top.sv
// AXI SRAM top level
`timescale 1ns/1ps

module axi_sram_top import axi_sram_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    // write address channel
    input  logic       aw_valid_i,
    output logic       aw_ready_o,
    input  id_t        aw_id_i,
    input  addr_t      aw_addr_i,
    input  len_t       aw_len_i,
    input  burst_e     aw_burst_i,
    // write data channel
    input  logic       w_valid_i,
    output logic       w_ready_o,
    input  data_t      w_data_i,
    input  strb_t      w_strb_i,
    input  logic       w_last_i,
    // write response channel
    output logic       b_valid_o,
    input  logic       b_ready_i,
    output id_t        b_id_o,
    output logic [1:0] b_resp_o,
    // read address channel
    input  logic       ar_valid_i,
    output logic       ar_ready_o,
    input  id_t        ar_id_i,
    input  addr_t      ar_addr_i,
    input  len_t       ar_len_i,
    input  burst_e     ar_burst_i,
    // read data channel
    output logic       r_valid_o,
    input  logic       r_ready_i,
    output id_t        r_id_o,
    output data_t      r_data_o,
    output logic [1:0] r_resp_o,
    output logic       r_last_o
);

    // adapter to memory
    logic      mem_req;
    logic      mem_we;
    word_idx_t mem_idx;
    strb_t     mem_be;
    data_t     mem_wdata;
    data_t     mem_rdata;

    // adapter to address generator
    addr_t     cur_addr;
    addr_t     start_addr;
    len_t      burst_len;
    burst_e    burst_type;
    addr_t     next_addr;

    // --------------------------------------------------
    // protocol adapter
    // --------------------------------------------------
    axi_mem_if u_axi_mem_if (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .aw_valid_i   (aw_valid_i),
        .aw_ready_o   (aw_ready_o),
        .aw_id_i      (aw_id_i),
        .aw_addr_i    (aw_addr_i),
        .aw_len_i     (aw_len_i),
        .aw_burst_i   (aw_burst_i),
        .w_valid_i    (w_valid_i),
        .w_ready_o    (w_ready_o),
        .w_data_i     (w_data_i),
        .w_strb_i     (w_strb_i),
        .w_last_i     (w_last_i),
        .b_valid_o    (b_valid_o),
        .b_ready_i    (b_ready_i),
        .b_id_o       (b_id_o),
        .b_resp_o     (b_resp_o),
        .ar_valid_i   (ar_valid_i),
        .ar_ready_o   (ar_ready_o),
        .ar_id_i      (ar_id_i),
        .ar_addr_i    (ar_addr_i),
        .ar_len_i     (ar_len_i),
        .ar_burst_i   (ar_burst_i),
        .r_valid_o    (r_valid_o),
        .r_ready_i    (r_ready_i),
        .r_id_o       (r_id_o),
        .r_data_o     (r_data_o),
        .r_resp_o     (r_resp_o),
        .r_last_o     (r_last_o),
        .mem_req_o    (mem_req),
        .mem_we_o     (mem_we),
        .mem_idx_o    (mem_idx),
        .mem_be_o     (mem_be),
        .mem_wdata_o  (mem_wdata),
        .mem_rdata_i  (mem_rdata),
        .cur_addr_o   (cur_addr),
        .start_addr_o (start_addr),
        .len_o        (burst_len),
        .burst_o      (burst_type),
        .next_addr_i  (next_addr)
    );

    // next beat address, purely combinational
    axi_burst_addr u_axi_burst_addr (
        .cur_addr_i   (cur_addr),
        .start_addr_i (start_addr),
        .len_i        (burst_len),
        .burst_i      (burst_type),
        .next_addr_o  (next_addr)
    );

    // --------------------------------------------------
    // storage
    // --------------------------------------------------
    sram_array u_sram_array (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .req_i   (mem_req),
        .we_i    (mem_we),
        .idx_i   (mem_idx),
        .be_i    (mem_be),
        .wdata_i (mem_wdata),
        .rdata_o (mem_rdata)
    );

endmodule

//--- sim/axi_sram_assertions.sv
// AXI SRAM protocol checks
`timescale 1ns/1ps

module axi_sram_assertions import axi_sram_pkg::*; (
    input logic       clk_i,
    input logic       rst_ni,
    input logic       r_valid_i,
    input logic       r_ready_i,
    input id_t        r_id_i,
    input data_t      r_data_i,
    input logic [1:0] r_resp_i,
    input logic       r_last_i,
    input logic       b_valid_i,
    input logic       b_ready_i,
    input id_t        b_id_i,
    input logic [1:0] b_resp_i
);

    // failures seen so far, watched from the testbench
    int fail_count = 0;

    // --------------------------------------------------
    // payload must hold while the manager stalls
    // --------------------------------------------------
    r_payload_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (r_valid_i && !r_ready_i) |=>
        (r_valid_i && $stable({r_id_i, r_data_i, r_resp_i, r_last_i})))
        else begin
            fail_count++;
            $error("R payload changed while stalled");
        end

    b_payload_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (b_valid_i && !b_ready_i) |=> (b_valid_i && $stable({b_id_i, b_resp_i})))
        else begin
            fail_count++;
            $error("B payload changed while stalled");
        end

    // nothing valid while in reset
    no_valid_in_reset: assert property (@(posedge clk_i)
        !rst_ni |-> (!r_valid_i && !b_valid_i))
        else begin
            fail_count++;
            $error("R or B valid during reset");
        end

    // one transaction at a time, so never both responses
    r_b_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(r_valid_i && b_valid_i))
        else begin
            fail_count++;
            $error("R and B valid together");
        end

endmodule

bind axi_sram_top axi_sram_assertions u_assertions (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .r_valid_i (r_valid_o),
    .r_ready_i (r_ready_i),
    .r_id_i    (r_id_o),
    .r_data_i  (r_data_o),
    .r_resp_i  (r_resp_o),
    .r_last_i  (r_last_o),
    .b_valid_i (b_valid_o),
    .b_ready_i (b_ready_i),
    .b_id_i    (b_id_o),
    .b_resp_i  (b_resp_o)
);

//--- sim/tb_axi_sram.sv
// AXI SRAM testbench
`timescale 1ns/1ps

module tb_axi_sram import axi_sram_pkg::*; ();

    // about 200 bursts, worst case under back-pressure times four
    localparam int TIMEOUT_CYCLES = 20000;

    logic       clk_i = 1'b0;
    logic       rst_ni;
    logic       aw_valid_i, aw_ready_o;
    id_t        aw_id_i;
    addr_t      aw_addr_i;
    len_t       aw_len_i;
    burst_e     aw_burst_i;
    logic       w_valid_i, w_ready_o;
    data_t      w_data_i;
    strb_t      w_strb_i;
    logic       w_last_i;
    logic       b_valid_o;
    logic       b_ready_i = 1'b0;
    id_t        b_id_o;
    logic [1:0] b_resp_o;
    logic       ar_valid_i, ar_ready_o;
    id_t        ar_id_i;
    addr_t      ar_addr_i;
    len_t       ar_len_i;
    burst_e     ar_burst_i;
    logic       r_valid_o;
    logic       r_ready_i = 1'b0;
    id_t        r_id_o;
    data_t      r_data_o;
    logic [1:0] r_resp_o;
    logic       r_last_o;

    // shadow copy of the memory
    data_t shadow [MEM_DEPTH];
    // expected responses, in order
    data_t exp_rdata [$];
    bit    exp_rlast [$];
    id_t   exp_rid [$];
    id_t   exp_bid [$];
    // random stalls on ready and gaps on w_valid
    bit    bp_en = 1'b0;
    int    cycle_cnt = 0;

    axi_sram_top UUT (.*);

    always #10 clk_i = ~clk_i;

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    // byte address of beat n of a burst
    function automatic addr_t expected_addr(input addr_t start, input len_t len,
                                            input burst_e burst, input int beat);
        int size;
        int lower;
        expected_addr = start + addr_t'(4 * beat);
        if (burst == FIXED) begin
            expected_addr = start;
        end else if (burst == WRAP && (len == 1 || len == 3 || len == 7 || len == 15)) begin
            size = (int'(len) + 1) * 4;
            lower = (int'(start) / size) * size;
            expected_addr = addr_t'(lower + (int'(start) - lower + 4 * beat) % size);
        end
    endfunction

    // memory aliases every 1 KiB
    function automatic word_idx_t word_of(input addr_t a);
        return a[9:2];
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] act,
                               input logic [31:0] exp);
        if (act !== exp) begin
            abort_run($sformatf("ERROR: %s = 0x%h, expected 0x%h", name, act, exp));
        end
    endtask

    // --------------------------------------------------
    // drivers
    // --------------------------------------------------
    task automatic drive_wbeat(input int beat, input len_t len, input bit part_strb);
        w_data_i  <= data_t'($urandom);
        w_strb_i  <= part_strb ? strb_t'($urandom) : {STRB_WIDTH{1'b1}};
        w_last_i  <= (beat == int'(len));
        w_valid_i <= !bp_en || ($urandom_range(3) != 0);
    endtask

    task automatic write_burst(input id_t id, input addr_t addr, input len_t len,
                               input burst_e burst, input bit part_strb);
        int beat;
        word_idx_t w;
        beat = 0;
        exp_bid.push_back(id);
        aw_valid_i <= 1'b1;
        aw_id_i    <= id;
        aw_addr_i  <= addr;
        aw_len_i   <= len;
        aw_burst_i <= burst;
        drive_wbeat(0, len, part_strb);
        while (beat <= int'(len)) begin
            @(posedge clk_i);
            if (aw_valid_i && aw_ready_o) begin
                aw_valid_i <= 1'b0;
            end
            if (w_valid_i && w_ready_o) begin
                // merge the accepted beat into the shadow memory
                w = word_of(expected_addr(addr, len, burst, beat));
                for (int b = 0; b < STRB_WIDTH; b++) begin
                    if (w_strb_i[b]) begin
                        shadow[w][8*b +: 8] = w_data_i[8*b +: 8];
                    end
                end
                beat++;
                if (beat <= int'(len)) begin
                    drive_wbeat(beat, len, part_strb);
                end else begin
                    w_valid_i <= 1'b0;
                end
            end else if (!w_valid_i) begin
                w_valid_i <= !bp_en || ($urandom_range(3) != 0);
            end
        end
        do @(posedge clk_i); while (!(b_valid_o && b_ready_i));
    endtask

    task automatic read_burst(input id_t id, input addr_t addr, input len_t len,
                              input burst_e burst);
        int beats;
        // expected data is taken when the read is issued
        for (int n = 0; n <= int'(len); n++) begin
            exp_rdata.push_back(shadow[word_of(expected_addr(addr, len, burst, n))]);
            exp_rlast.push_back(n == int'(len));
            exp_rid.push_back(id);
        end
        ar_valid_i <= 1'b1;
        ar_id_i    <= id;
        ar_addr_i  <= addr;
        ar_len_i   <= len;
        ar_burst_i <= burst;
        do @(posedge clk_i); while (!ar_ready_o);
        ar_valid_i <= 1'b0;
        beats = 0;
        while (beats <= int'(len)) begin
            @(posedge clk_i);
            if (r_valid_o && r_ready_i) begin
                beats++;
            end
        end
    endtask

    // --------------------------------------------------
    // ready generation, monitor and watchdog
    // --------------------------------------------------
    always @(posedge clk_i) begin
        r_ready_i <= !bp_en || ($urandom_range(3) != 0);
        b_ready_i <= !bp_en || ($urandom_range(2) != 0);
    end

    always @(posedge clk_i) begin
        if (rst_ni && r_valid_o && r_ready_i) begin
            if (exp_rdata.size() == 0) begin
                abort_run("read beat arrived with no read outstanding");
            end else begin
                check_value("r_data_o", r_data_o, exp_rdata.pop_front());
                check_value("r_last_o", 32'(r_last_o), 32'(exp_rlast.pop_front()));
                check_value("r_id_o", 32'(r_id_o), 32'(exp_rid.pop_front()));
                check_value("r_resp_o", 32'(r_resp_o), 32'(RESP_OKAY));
            end
        end
        if (rst_ni && b_valid_o && b_ready_i) begin
            if (exp_bid.size() == 0) begin
                abort_run("write response arrived with no write outstanding");
            end else begin
                check_value("b_id_o", 32'(b_id_o), 32'(exp_bid.pop_front()));
                check_value("b_resp_o", 32'(b_resp_o), 32'(RESP_OKAY));
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            abort_run("timeout, the tests did not finish in time");
        end else if (UUT.u_assertions.fail_count != 0) begin
            abort_run("a protocol assertion failed");
        end
    end

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        addr_t  addr;
        len_t   len;
        burst_e burst;
        int     kind;
        void'($urandom(32'haf70));
        rst_ni     <= 1'b0;
        aw_valid_i <= 1'b0;
        aw_id_i    <= '0;
        aw_addr_i  <= '0;
        aw_len_i   <= '0;
        aw_burst_i <= INCR;
        w_valid_i  <= 1'b0;
        w_data_i   <= '0;
        w_strb_i   <= '0;
        w_last_i   <= 1'b0;
        ar_valid_i <= 1'b0;
        ar_id_i    <= '0;
        ar_addr_i  <= '0;
        ar_len_i   <= '0;
        ar_burst_i <= INCR;
        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(posedge clk_i);

        // fill the whole 1 KiB so every read has a known value
        for (int i = 0; i < 16; i++) begin
            write_burst(id_t'(i), addr_t'(64 * i), 8'd15, INCR, 1'b0);
        end
        // incr bursts of every length
        for (int i = 0; i < 16; i++) begin
            write_burst(id_t'(i), addr_t'(16'h0100 + 64 * i), len_t'(i), INCR, 1'b0);
            read_burst(id_t'(15 - i), addr_t'(16'h0100 + 64 * i), len_t'(i), INCR);
        end
        // wrap bursts starting mid window
        for (int k = 0; k < 4; k++) begin
            len = len_t'((2 << k) - 1);
            addr = addr_t'(16'h0200 + (int'(len) + 1) * 2);
            write_burst(id_t'(k + 4), addr, len, WRAP, 1'b0);
            read_burst(id_t'(k + 8), addr, len, WRAP);
            // linear read of the window shows where each beat landed
            read_burst(id_t'(k + 12), 16'h0200, len, INCR);
        end
        // fixed bursts, last beat wins per byte
        write_burst(4'h6, 16'h0300, 8'd7, FIXED, 1'b1);
        read_burst(4'h7, 16'h0300, 8'd3, FIXED);
        // partial strobes keep the old bytes
        for (int i = 0; i < 4; i++) begin
            write_burst(id_t'(i), addr_t'(16'h0380 + 16 * i), 8'd5, INCR, 1'b1);
            read_burst(id_t'(i + 1), addr_t'(16'h0380 + 16 * i), 8'd5, INCR);
        end

        // random traffic under back-pressure
        bp_en = 1'b1;
        for (int i = 0; i < 120; i++) begin
            kind = $urandom_range(2);
            burst = (kind == 0) ? FIXED : (kind == 1) ? INCR : WRAP;
            if (burst == WRAP) begin
                len = len_t'((2 << $urandom_range(3)) - 1);
            end else begin
                len = len_t'($urandom_range(15));
            end
            addr = addr_t'($urandom) & 16'hfffc;
            if ($urandom_range(1) == 0) begin
                write_burst(id_t'($urandom), addr, len, burst, 1'b1);
            end else begin
                read_burst(id_t'($urandom), addr, len, burst);
            end
        end

        // ar and aw together, read sees the old data
        for (int i = 0; i < 3; i++) begin
            fork
                read_burst(4'h2, addr_t'(16'h0040 + 64 * i), 8'd3, INCR);
                write_burst(4'h9, addr_t'(16'h0040 + 64 * i), 8'd3, INCR, 1'b0);
            join
            read_burst(4'h3, addr_t'(16'h0040 + 64 * i), 8'd3, INCR);
        end

        repeat (4) @(posedge clk_i);
        if (exp_rdata.size() != 0 || exp_bid.size() != 0) begin
            abort_run("responses still missing at the end of the run");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

//--- axi_sram.f
rtl/axi_sram_pkg.sv
rtl/axi_burst_addr.sv
rtl/sram_array.sv
rtl/axi_mem_if.sv
rtl/axi_sram_top.sv
sim/axi_sram_assertions.sv
sim/tb_axi_sram.sv

//--- Makefile
# Verilator build for the AXI SRAM testbench

VERILATOR ?= verilator
TOP       ?= tb_axi_sram
FILELIST  ?= axi_sram.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
# let assertion failures reach the testbench so it can end the run itself
RUN_ARGS  ?= +verilator+error+limit+10

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulation binary is the pass or fail result
run: $(BIN)
	./$(BIN) $(RUN_ARGS)

clean:
	rm -rf $(BUILD_DIR)
